/* common/speech_pkg.sv */
/*
 * Shared types and defaults for the speech audio path.
 * Coefficients are signed fixed point with COEF_FRAC fraction bits; the
 * defaults model the two op-amp low-pass stages at a 256-clock sample period.
 */
`default_nettype none

package speech_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths and formats
	////////////////////////////////////////////////////////////////////////////

	// Fraction bits of every filter coefficient
	localparam int COEF_FRAC = 15;

	// Clocks per audio sample, about 46.9 kHz at a 12 MHz system clock
	localparam int DEF_SAMPLE_DIV = 256;

	// Number of entries in a coefficient set
	localparam int MAX_STAGES = 4;

	// Speech sample with the 0x8000 offset removed
	typedef logic signed [15:0] pcm_t;

	// Unsigned 16-bit word as seen on the board side
	typedef logic [15:0] uword_t;

	// Sound-board DAC byte
	typedef logic [7:0] snd_t;

	typedef logic signed [21:0] coef_t;

	// One biquad stage, a* feedback and b* feed-forward taps
	typedef struct packed {
		coef_t a2;
		coef_t a3;
		coef_t b1;
		coef_t b2;
		coef_t b3;
	} iir_coef_t;

	// One sample moving down the chain, valid for a single clock
	typedef struct packed {
		logic  valid;
		pcm_t  speech;
		snd_t  sound;
		logic  filter_en;
	} sample_t;

	typedef iir_coef_t [MAX_STAGES-1:0] coef_set_t;

	////////////////////////////////////////////////////////////////////////////
	// Default coefficients
	////////////////////////////////////////////////////////////////////////////

	// Unity gain, no feedback
	localparam iir_coef_t PASS_COEFS = '{a2: 0, a3: 0, b1: 32768, b2: 0, b3: 0};

	// Stage 0 is the first op-amp (gain about 4.2), stage 1 the unity-gain one
	localparam coef_set_t DEF_STAGE_COEFS = '{
		0: '{a2: -53169, a3: 23491, b1: 3229, b2: 6458, b3: 3229},
		1: '{a2: -45172, a3: 17306, b1: 1225, b2: 2452, b3: 1225},
		2: PASS_COEFS,
		3: PASS_COEFS
	};

endpackage

`default_nettype wire

/* hw/speech_sampler.sv */
/*
 * Fixed-rate capture of the speech word, sound byte and filter mode.
 * Inputs are taken as they are, so they must be stable at the capture clock.
 * raw_smp.valid pulses for one clock every SAMPLE_DIV clocks.
 */
`timescale 1ns/1ps
`default_nettype none

module speech_sampler #(
	parameter int SAMPLE_DIV = speech_pkg::DEF_SAMPLE_DIV
) (
	input  wire logic               clk_sys,
	input  wire logic               arst_n,
	input  wire speech_pkg::uword_t speech_in,
	input  wire speech_pkg::snd_t   sound_in,
	input  wire logic               filter_en,
	output speech_pkg::sample_t     raw_smp
);

	import speech_pkg::*;

	localparam int CNT_W = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;

	logic [CNT_W-1:0] div_cnt;
	logic             cap_tick;
	logic             cap_valid;
	pcm_t             cap_speech;
	snd_t             cap_sound;
	logic             cap_fen;

	// Last count of the period
	assign cap_tick = (div_cnt == CNT_W'(SAMPLE_DIV - 1));

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			div_cnt   <= '0;
			cap_valid <= 1'b0;
		end
		else
		begin
			cap_valid <= cap_tick;
			if (cap_tick)
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;
		end
	end

	// Flipping the MSB turns offset binary into two's complement
	always_ff @(posedge clk_sys)
	begin
		if (cap_tick)
		begin
			cap_speech <= {~speech_in[15], speech_in[14:0]};
			cap_sound  <= sound_in;
			cap_fen    <= filter_en;
		end
	end

	assign raw_smp = '{valid: cap_valid, speech: cap_speech, sound: cap_sound,
		filter_en: cap_fen};

endmodule

`default_nettype wire

/* hw/speech_filter/iir_biquad_stage.sv */
/*
 * Direct-form-I biquad, one output per input valid, one clock of latency.
 * The full-width result is scaled by COEF_FRAC and clamped to the pcm_t range.
 * History runs on every valid sample, whatever filter_en says.
 */
`timescale 1ns/1ps
`default_nettype none

module iir_biquad_stage #(
	parameter speech_pkg::iir_coef_t COEFS = speech_pkg::PASS_COEFS
) (
	input  wire logic                clk_sys,
	input  wire logic                arst_n,
	input  wire speech_pkg::sample_t smp_in,
	output speech_pkg::sample_t      smp_out
);

	import speech_pkg::*;

	// 22x16 products plus headroom for five terms
	localparam int ACC_W = $bits(coef_t) + $bits(pcm_t) + 3;

	localparam logic signed [ACC_W-1:0] PCM_MAX = 32767;
	localparam logic signed [ACC_W-1:0] PCM_MIN = -32768;

	// Past inputs and outputs, y1 doubles as the output sample
	pcm_t x1;
	pcm_t x2;
	pcm_t y1;
	pcm_t y2;

	logic signed [ACC_W-1:0] acc;
	logic signed [ACC_W-1:0] acc_shr;
	pcm_t                    y_new;

	logic out_valid;
	snd_t out_sound;
	logic out_fen;

	////////////////////////////////////////////////////////////////////////////
	// Difference equation
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		acc = $signed(COEFS.b1) * smp_in.speech
			+ $signed(COEFS.b2) * x1
			+ $signed(COEFS.b3) * x2
			- $signed(COEFS.a2) * y1
			- $signed(COEFS.a3) * y2;

		acc_shr = acc >>> COEF_FRAC;

		// Clamp instead of wrapping on large steps
		if (acc_shr > PCM_MAX)
			y_new = {1'b0, {15{1'b1}}};
		else if (acc_shr < PCM_MIN)
			y_new = {1'b1, {15{1'b0}}};
		else
			y_new = acc_shr[15:0];
	end

	////////////////////////////////////////////////////////////////////////////
	// History and output registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			x1        <= '0;
			x2        <= '0;
			y1        <= '0;
			y2        <= '0;
			out_valid <= 1'b0;
		end
		else
		begin
			out_valid <= smp_in.valid;
			if (smp_in.valid)
			begin
				x2 <= x1;
				x1 <= smp_in.speech;
				y2 <= y1;
				y1 <= y_new;
			end
		end
	end

	// Side fields follow the speech sample through the stage
	always_ff @(posedge clk_sys)
	begin
		if (smp_in.valid)
		begin
			out_sound <= smp_in.sound;
			out_fen   <= smp_in.filter_en;
		end
	end

	assign smp_out = '{valid: out_valid, speech: y1, sound: out_sound,
		filter_en: out_fen};

endmodule

`default_nettype wire

/* hw/audio_mixer.sv */
/*
 * Picks raw or filtered speech by the filter_en carried with each sample,
 * then mixes it with the sound byte as the board's summing amp does.
 * Output is unsigned, 3 bits below full scale, one clock after the valid.
 */
`timescale 1ns/1ps
`default_nettype none

module audio_mixer (
	input  wire logic                clk_sys,
	input  wire logic                arst_n,
	input  wire speech_pkg::sample_t raw_smp,
	input  wire speech_pkg::sample_t filt_smp,
	output speech_pkg::uword_t       audio_out,
	output logic                     audio_valid
);

	import speech_pkg::*;

	logic        take_raw;
	logic        take_filt;
	sample_t     sel_smp;
	uword_t      speech_u;
	logic [16:0] mix_sum;

	// Each sample is used once, on the path its own mode bit names
	assign take_raw  = raw_smp.valid & ~raw_smp.filter_en;
	assign take_filt = filt_smp.valid & filt_smp.filter_en;

	assign sel_smp = take_filt ? filt_smp : raw_smp;

	// Back to offset binary
	assign speech_u = {~sel_smp.speech[15], sel_smp.speech[14:0]};

	assign mix_sum = {1'b0, sel_smp.sound, 8'd0} + {1'b0, speech_u};

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			audio_out   <= '0;
			audio_valid <= 1'b0;
		end
		else
		begin
			audio_valid <= take_raw | take_filt;
			if (take_raw | take_filt)
				audio_out <= uword_t'(mix_sum >> 3);
		end
	end

endmodule

`default_nettype wire

/* hw/speech_audio_top.sv */
/*
 * Speech audio path: sampler, NUM_STAGES biquads and the output mixer.
 * NUM_STAGES must be 1 to MAX_STAGES; stage k uses STAGE_COEFS[k].
 * Latency from capture is 2 clocks raw and NUM_STAGES+2 filtered.
 */
`timescale 1ns/1ps
`default_nettype none

module speech_audio_top #(
	parameter int                    NUM_STAGES  = 2,
	parameter int                    SAMPLE_DIV  = speech_pkg::DEF_SAMPLE_DIV,
	parameter speech_pkg::coef_set_t STAGE_COEFS = speech_pkg::DEF_STAGE_COEFS
) (
	input  wire logic               clk_sys,
	input  wire logic               arst_n,
	input  wire speech_pkg::uword_t speech_in,
	input  wire speech_pkg::snd_t   sound_in,
	input  wire logic               filter_en,
	output wire speech_pkg::uword_t audio_out,
	output wire logic               audio_valid
);

	import speech_pkg::*;

	wire sample_t raw_smp;
	wire sample_t filt_smp;

	// Entry 0 is the sampler output, entry k+1 the output of stage k
	wire sample_t stage_smp [0:NUM_STAGES];

	////////////////////////////////////////////////////////////////////////////
	// Capture
	////////////////////////////////////////////////////////////////////////////

	speech_sampler #(
		.SAMPLE_DIV (SAMPLE_DIV)
	) sampler0 (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.speech_in (speech_in),
		.sound_in  (sound_in),
		.filter_en (filter_en),
		.raw_smp   (raw_smp)
	);

	assign stage_smp[0] = raw_smp;

	////////////////////////////////////////////////////////////////////////////
	// Op-amp filter chain
	////////////////////////////////////////////////////////////////////////////

	// Every stage sees every sample so the history never has gaps
	for (genvar k = 0; k < NUM_STAGES; k++)
	begin : g_stage
		iir_biquad_stage #(
			.COEFS (STAGE_COEFS[k])
		) stage (
			.clk_sys (clk_sys),
			.arst_n  (arst_n),
			.smp_in  (stage_smp[k]),
			.smp_out (stage_smp[k+1])
		);
	end

	assign filt_smp = stage_smp[NUM_STAGES];

	////////////////////////////////////////////////////////////////////////////
	// Output mix
	////////////////////////////////////////////////////////////////////////////

	audio_mixer mixer0 (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.raw_smp     (raw_smp),
		.filt_smp    (filt_smp),
		.audio_out   (audio_out),
		.audio_valid (audio_valid)
	);

endmodule

`default_nettype wire

/* bench/speech_model.svh */
/*
 * Reference model of the speech path, included inside the testbench module.
 * Needs NUM_STAGES declared before the include; stages past 1 are pass-through.
 * One call of run_filter_chain per captured sample, in capture order.
 */
`ifndef SPEECH_MODEL_SVH
`define SPEECH_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Model state
////////////////////////////////////////////////////////////////////////////

int hist_x1 [0:NUM_STAGES-1];
int hist_x2 [0:NUM_STAGES-1];
int hist_y1 [0:NUM_STAGES-1];
int hist_y2 [0:NUM_STAGES-1];

logic [31:0] lfsr_state;

// Tap order is a2, a3, b1, b2, b3
function automatic longint coef_of(input int stage, input int tap);
	longint c;
	c = 0;
	if (stage == 0)
	begin
		case (tap)
			0: c = -53169;
			1: c = 23491;
			3: c = 6458;
			default: c = 3229;
		endcase
	end
	else if (stage == 1)
	begin
		case (tap)
			0: c = -45172;
			1: c = 17306;
			3: c = 2452;
			default: c = 1225;
		endcase
	end
	else if (tap == 2)
		c = 32768;
	return c;
endfunction

// Right-shifting Galois form, taps 32, 31, 29 and 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	if (s[0])
		return (s >> 1) ^ 32'hD000_0001;
	else
		return s >> 1;
endfunction

task automatic model_reset();
	int k;
	for (k = 0; k < NUM_STAGES; k++)
	begin
		hist_x1[k] = 0;
		hist_x2[k] = 0;
		hist_y1[k] = 0;
		hist_y2[k] = 0;
	end
	lfsr_state = 32'h4d6f;
endtask

// One LFSR step per bit, LSB first
task automatic take_rand_word(output logic [15:0] word);
	int b;
	for (b = 0; b < 16; b++)
	begin
		lfsr_state = lfsr_step(lfsr_state);
		word[b] = lfsr_state[0];
	end
endtask

// Pushes one signed sample through every stage and updates all histories
task automatic run_filter_chain(input int x_in, output int y_out);
	int     x;
	int     y;
	int     k;
	longint acc;
	longint shr;
	x = x_in;
	for (k = 0; k < NUM_STAGES; k++)
	begin
		acc = coef_of(k, 2) * x + coef_of(k, 3) * hist_x1[k] + coef_of(k, 4) * hist_x2[k]
			- coef_of(k, 0) * hist_y1[k] - coef_of(k, 1) * hist_y2[k];
		shr = acc >>> 15;
		if (shr > 32767)
			y = 32767;
		else if (shr < -32768)
			y = -32768;
		else
			y = int'(shr);
		hist_x2[k] = hist_x1[k];
		hist_x1[k] = x;
		hist_y2[k] = hist_y1[k];
		hist_y1[k] = y;
		x = y;
	end
	y_out = x;
endtask

// Unsigned speech plus sound byte in the upper half, scaled down by 8
function automatic int mix_expect(input int pcm, input int snd);
	return ((snd << 8) + (pcm + 32768)) >> 3;
endfunction

`endif

/* bench/speech_audio_tb.sv */
/*
 * Testbench for speech_audio_top with default parameters.
 * Inputs change 2 ns after the capture edge and hold for a whole sample
 * period; outputs are sampled on the falling edge.
 */
`timescale 1ns/1ps
`default_nettype none

module speech_audio_tb;

	localparam int SAMPLE_DIV = speech_pkg::DEF_SAMPLE_DIV;
	localparam int NUM_STAGES = 2;
	localparam int NUM_ROWS   = 7;

	localparam int SRC_CONST = 0;
	localparam int SRC_LFSR  = 1;
	localparam int SRC_ALT   = 2;

	logic        clk_sys;
	logic        arst_n;
	logic [15:0] speech_in;
	logic [7:0]  sound_in;
	logic        filter_en;
	wire  [15:0] audio_out;
	wire         audio_valid;

	`include "speech_model.svh"

	// Stimulus table
	string       row_name  [0:NUM_ROWS-1];
	int          row_src   [0:NUM_ROWS-1];
	logic [15:0] row_word  [0:NUM_ROWS-1];
	logic [7:0]  row_sound [0:NUM_ROWS-1];
	logic        row_fen   [0:NUM_ROWS-1];
	int          row_count [0:NUM_ROWS-1];

	// Expected results, in capture order
	int exp_val_q  [$];
	int exp_tick_q [$];
	int exp_row_q  [$];

	int  tick;
	bit  seen_first;
	int  value_errs;
	int  timing_errs;
	int  timeout_errs;

	speech_audio_top dut0 (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.speech_in   (speech_in),
		.sound_in    (sound_in),
		.filter_en   (filter_en),
		.audio_out   (audio_out),
		.audio_valid (audio_valid)
	);

	always #20 clk_sys = ~clk_sys;

	task automatic set_row(input int idx, input string name, input int src,
		input logic [15:0] word, input logic [7:0] snd, input logic fen, input int cnt);
		row_name[idx]  = name;
		row_src[idx]   = src;
		row_word[idx]  = word;
		row_sound[idx] = snd;
		row_fen[idx]   = fen;
		row_count[idx] = cnt;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Output monitor
	////////////////////////////////////////////////////////////////////////////

	// Ticks count falling edges since reset release
	always @(negedge clk_sys)
	begin
		int e_val;
		int e_tick;
		int e_row;
		if (!arst_n)
		begin
			if (audio_valid !== 1'b0 || audio_out !== 16'd0)
			begin
				$display("audio outputs are not cleared while reset is asserted");
				timing_errs++;
			end
		end
		else
		begin
			tick = tick + 1;
			if (!seen_first && audio_valid !== 1'b1 && audio_out !== 16'd0)
			begin
				$display("audio_out is not zero before the first sample at tick %0d", tick);
				value_errs++;
			end
			if (audio_valid === 1'b1)
			begin
				seen_first = 1'b1;
				if (exp_val_q.size() == 0)
				begin
					$display("audio_valid at tick %0d with no sample pending", tick);
					timing_errs++;
				end
				else
				begin
					e_val  = exp_val_q.pop_front();
					e_tick = exp_tick_q.pop_front();
					e_row  = exp_row_q.pop_front();
					if (tick != e_tick)
					begin
						$display("ERR %s latency: expected tick %0d, actual tick %0d",
							row_name[e_row], e_tick, tick);
						timing_errs++;
					end
					if (audio_out !== e_val[15:0])
					begin
						$display("ERR %s audio_out: expected %04h, actual %04h",
							row_name[e_row], e_val[15:0], audio_out);
						value_errs++;
					end
				end
			end
			else if (audio_valid !== 1'b0)
			begin
				$display("audio_valid is unknown at tick %0d", tick);
				timing_errs++;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int          r;
		int          i;
		int          sample_no;
		int          pcm_in;
		int          pcm_out;
		int          wait_cnt;
		logic [15:0] word;
		clk_sys      = 1'b0;
		arst_n       = 1'b0;
		speech_in    = 16'h8000;
		sound_in     = 8'h00;
		filter_en    = 1'b0;
		tick         = 0;
		seen_first   = 1'b0;
		value_errs   = 0;
		timing_errs  = 0;
		timeout_errs = 0;
		sample_no    = 0;

		set_row(0, "reset_bypass", SRC_CONST, 16'h8000, 8'h00, 1'b0, 2);
		set_row(1, "bypass_mix",   SRC_LFSR,  16'h0000, 8'h5a, 1'b0, 12);
		set_row(2, "filtered",     SRC_LFSR,  16'h0000, 8'h21, 1'b1, 16);
		set_row(3, "saturation",   SRC_ALT,   16'h0000, 8'h00, 1'b1, 32);
		set_row(4, "mode_to_raw",  SRC_LFSR,  16'h0000, 8'h80, 1'b0, 6);
		set_row(5, "mode_to_filt", SRC_LFSR,  16'h0000, 8'h80, 1'b1, 10);
		set_row(6, "dc_gain",      SRC_CONST, 16'h8600, 8'h10, 1'b1, 60);
		model_reset();

		repeat (3) @(posedge clk_sys);
		#2;
		arst_n = 1'b1;

		// Each pass holds one sample's inputs up to its capture edge
		for (r = 0; r < NUM_ROWS; r++)
		begin
			for (i = 0; i < row_count[r]; i++)
			begin
				// Full-scale levels last 8 samples so the stage-0 gain overshoots
				case (row_src[r])
					SRC_LFSR: take_rand_word(word);
					SRC_ALT:  word = i[3] ? 16'hFFFF : 16'h0000;
					default:  word = row_word[r];
				endcase
				speech_in = word;
				sound_in  = row_sound[r];
				filter_en = row_fen[r];
				sample_no++;

				pcm_in = int'(word) - 32768;
				run_filter_chain(pcm_in, pcm_out);
				if (row_fen[r])
				begin
					exp_val_q.push_back(mix_expect(pcm_out, row_sound[r]));
					exp_tick_q.push_back(sample_no * SAMPLE_DIV + NUM_STAGES + 2);
				end
				else
				begin
					exp_val_q.push_back(mix_expect(pcm_in, row_sound[r]));
					exp_tick_q.push_back(sample_no * SAMPLE_DIV + 2);
				end
				exp_row_q.push_back(r);

				repeat (SAMPLE_DIV) @(posedge clk_sys);
				#2;
			end
		end

		// Let the last samples drain out of the pipeline
		wait_cnt = 0;
		while (exp_val_q.size() != 0 && wait_cnt < 4 * SAMPLE_DIV)
		begin
			@(posedge clk_sys);
			wait_cnt++;
		end
		if (exp_val_q.size() != 0)
		begin
			$display("timeout: %0d samples never produced audio_valid", exp_val_q.size());
			timeout_errs++;
		end

		$display("errors: value %0d, timing %0d, timeout %0d",
			value_errs, timing_errs, timeout_errs);
		if (value_errs + timing_errs + timeout_errs == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+bench
common/speech_pkg.sv
hw/speech_sampler.sv
hw/speech_filter/iir_biquad_stage.sv
hw/audio_mixer.sv
hw/speech_audio_top.sv
bench/speech_audio_tb.sv
